// File: hdl/bpPkg.sv
package bpPkg;

    //////////////////////////////////////////////////
    // widths and table geometry
    //////////////////////////////////////////////////
    localparam int ADDR_WIDTH     = 32;                     // processor address width
    localparam int PAIR_IDX_WIDTH = 5;                      // pc[7:3], 32 pair sets
    localparam int TAG_WIDTH      = 24;                     // pc[31:8]
    localparam int HIST_IDX_WIDTH = 6;                      // pc[7:2], one per instruction
    localparam int WORD_WIDTH     = ADDR_WIDTH - 2;         // target word address
    localparam int PAIR_SETS      = 1 << PAIR_IDX_WIDTH;
    localparam int HIST_SETS      = 1 << HIST_IDX_WIDTH;
    localparam int NUM_SLOTS      = 2;                      // lower and upper

    localparam int SLOT_LOWER = 0;
    localparam int SLOT_UPPER = 1;

    // read port numbering of the tag files
    localparam int TAG_READS    = 3;
    localparam int TAG_RD_BUILD = 0;                        // decode stage
    localparam int TAG_RD_CHECK = 1;                        // execute stage
    localparam int TAG_RD_FETCH = 2;                        // fetch stage

    // read port numbering of the history file
    localparam int HIST_READS      = 3;
    localparam int HIST_RD_RESOLVE = 0;
    localparam int HIST_RD_EVEN    = 1;                     // lower instruction
    localparam int HIST_RD_ODD     = 2;                     // upper instruction

    typedef logic [ADDR_WIDTH-1:0]     pcT;
    typedef logic [PAIR_IDX_WIDTH-1:0] pairIdxT;
    typedef logic [TAG_WIDTH-1:0]      tagT;
    typedef logic [HIST_IDX_WIDTH-1:0] histIdxT;
    typedef logic [1:0]                ctrT;                // 2-bit saturating counter

    localparam ctrT CTR_MAX = 2'b11;
    localparam ctrT CTR_MIN = 2'b00;

    // first-resolve counter seeds, counter 3 down to 0
    localparam logic [7:0] CTR_INIT_BACK = 8'b10_10_10_01;
    localparam logic [7:0] CTR_INIT_FWD  = 8'b10_01_01_01;

    typedef enum logic [1:0] {
        NONE  = 2'b00,                                      // not a branch
        COND  = 2'b01,                                      // conditional
        JUMP  = 2'b10,                                      // unconditional
        OTHER = 2'b11                                       // never stored
    } branchTypeT;

    //////////////////////////////////////////////////
    // payloads
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [WORD_WIDTH-1:0] target;                      // target[31:2]
        branchTypeT            brType;
    } slotEntryT;

    typedef struct packed {
        branchTypeT brType;
        pcT         target;
    } slotReqT;

    typedef struct packed {
        logic    en;                                        // one-cycle strobe
        pcT      pc;                                        // pair address
        slotReqT lower;
        slotReqT upper;
    } buildReqT;

    typedef struct packed {
        logic exist;
        logic insert;
        logic isPair;
    } buildStatusT;

    typedef struct packed {
        logic [1:0]      lastOutcomes;                      // older outcome in bit 1
        ctrT      [3:0]  ctr;                               // ctr[k] used when lastOutcomes == k
    } histEntryT;

    typedef struct packed {
        logic       en;
        pcT         pc;                                     // resolved instruction
        pcT         target;
        branchTypeT brType;
        logic       taken;
    } resolveT;

    typedef struct packed {
        logic      exist;
        slotEntryT entry;
        histEntryT hist;
    } slotPredT;

    typedef struct packed {
        slotPredT lower;
        slotPredT upper;
    } fetchPredT;

    // address field helpers
    function automatic pairIdxT pairIdx(pcT pc);
        return pc[PAIR_IDX_WIDTH+2:3];
    endfunction

    function automatic tagT pairTag(pcT pc);
        return pc[ADDR_WIDTH-1:PAIR_IDX_WIDTH+3];
    endfunction

    function automatic histIdxT histIdx(pcT pc);
        return pc[HIST_IDX_WIDTH+1:2];
    endfunction

    function automatic logic isUseful(branchTypeT t);
        return (t == COND) || (t == JUMP);                  // only these get stored
    endfunction

endpackage

// File: hdl/regFile.sv
`timescale 1ns/1ps

module regFile #(
    parameter type payloadT  = logic [31:0],                // stored word
    parameter int  NUM_READS = 1,                           // combinational read ports
    parameter int  IDX_WIDTH = 5                            // address width
) (
    input  logic                                 clk,
    input  logic                                 wrEn,
    input  logic [IDX_WIDTH-1:0]                 wrAddr,
    input  payloadT                              wrData,
    input  logic [NUM_READS-1:0][IDX_WIDTH-1:0]  rdAddr,
    output payloadT [NUM_READS-1:0]              rdData
);

    localparam int DEPTH = 1 << IDX_WIDTH;

    payloadT mem [DEPTH];                                   // contents unknown until written

    //////////////////////////////////////////////////
    // single write port
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;                          // visible next cycle
        end
    end

    //////////////////////////////////////////////////
    // read ports, no latency
    //////////////////////////////////////////////////
    for (genvar r = 0; r < NUM_READS; r++) begin : gRead
        assign rdData[r] = mem[rdAddr[r]];                  // async lookup
    end

    // a write strobe with an unknown address would smear the array
    wrAddrKnown: assert property (
        @(posedge clk) wrEn |-> !$isunknown(wrAddr)
    ) else $error("regFile write with unknown address");

endmodule

// File: hdl/historyUpdate.sv
`timescale 1ns/1ps

module historyUpdate (
    input  bpPkg::histEntryT old,                           // stored entry
    input  logic             taken,                         // resolved direction
    output bpPkg::histEntryT updated
);

    import bpPkg::*;

    logic [1:0] sel;                                        // pattern picks the counter
    ctrT        cur;
    ctrT        nxt;

    assign sel = old.lastOutcomes;
    assign cur = old.ctr[sel];

    //////////////////////////////////////////////////
    // saturating counter step
    //////////////////////////////////////////////////
    always_comb begin
        if (taken) begin
            if (cur == CTR_MAX) begin
                nxt = cur;                                  // stuck at strongly taken
            end else begin
                nxt = cur + 2'd1;
            end
        end else begin
            if (cur == CTR_MIN) begin
                nxt = cur;                                  // stuck at strongly not taken
            end else begin
                nxt = cur - 2'd1;
            end
        end
    end

    //////////////////////////////////////////////////
    // new entry
    //////////////////////////////////////////////////
    always_comb begin
        updated          = old;                             // other counters untouched
        updated.ctr[sel] = nxt;
        // shift, older bit drops out
        updated.lastOutcomes = {old.lastOutcomes[0], taken};
    end

endmodule

// File: hdl/pairTargetBuffer.sv
`timescale 1ns/1ps

module pairTargetBuffer (
    input  logic                                       clk,
    input  logic                                       rstn,
    input  bpPkg::buildReqT                            build,        // decode stage
    input  bpPkg::pcT                                  exPc,         // execute stage
    input  bpPkg::pcT                                  fetchPc,      // fetch stage
    output bpPkg::buildStatusT                         buildStatus,
    output logic                                       exExist,
    output logic [bpPkg::NUM_SLOTS-1:0]                fetchExist,
    output bpPkg::slotEntryT [bpPkg::NUM_SLOTS-1:0]    fetchEntry
);

    import bpPkg::*;

    //////////////////////////////////////////////////
    // address fields of the three lookups
    //////////////////////////////////////////////////
    pairIdxT bIdx;                                          // build index
    pairIdxT eIdx;                                          // check index
    pairIdxT fIdx;                                          // fetch index
    tagT     bTag;
    tagT     eTag;
    tagT     fTag;

    assign bIdx = pairIdx(build.pc);
    assign eIdx = pairIdx(exPc);
    assign fIdx = pairIdx(fetchPc);
    assign bTag = pairTag(build.pc);
    assign eTag = pairTag(exPc);
    assign fTag = pairTag(fetchPc);                         // from the fetch pc itself

    pairIdxT [TAG_READS-1:0] tagRdAddr;

    assign tagRdAddr[TAG_RD_BUILD] = bIdx;
    assign tagRdAddr[TAG_RD_CHECK] = eIdx;
    assign tagRdAddr[TAG_RD_FETCH] = fIdx;

    //////////////////////////////////////////////////
    // per-slot storage
    //////////////////////////////////////////////////
    slotReqT   [NUM_SLOTS-1:0]                 slotReq;
    slotEntryT [NUM_SLOTS-1:0]                 slotWrData;
    tagT       [NUM_SLOTS-1:0][TAG_READS-1:0]  tagRd;
    logic      [NUM_SLOTS-1:0]                 useful;       // request type worth storing
    logic      [NUM_SLOTS-1:0]                 slotWrEn;
    logic      [NUM_SLOTS-1:0]                 buildHit;     // stored tag == build tag
    logic      [NUM_SLOTS-1:0]                 vldUseful;    // valid and useful request
    logic      [NUM_SLOTS-1:0][PAIR_SETS-1:0]  valid;

    assign slotReq[SLOT_LOWER] = build.lower;
    assign slotReq[SLOT_UPPER] = build.upper;

    for (genvar s = 0; s < NUM_SLOTS; s++) begin : gSlot
        assign useful[s]   = isUseful(slotReq[s].brType);
        assign slotWrEn[s] = build.en & useful[s];          // only useful types land

        assign slotWrData[s].target = slotReq[s].target[ADDR_WIDTH-1:2];
        assign slotWrData[s].brType = slotReq[s].brType;

        regFile #(
            .payloadT  (tagT),
            .NUM_READS (TAG_READS),
            .IDX_WIDTH (PAIR_IDX_WIDTH)
        ) uTagFile (
            .clk    (clk),
            .wrEn   (slotWrEn[s]),
            .wrAddr (bIdx),
            .wrData (bTag),
            .rdAddr (tagRdAddr),
            .rdData (tagRd[s])
        );

        regFile #(
            .payloadT  (slotEntryT),
            .NUM_READS (1),
            .IDX_WIDTH (PAIR_IDX_WIDTH)
        ) uEntryFile (
            .clk    (clk),
            .wrEn   (slotWrEn[s]),
            .wrAddr (bIdx),
            .wrData (slotWrData[s]),
            .rdAddr (fIdx),                                 // fetch only
            .rdData (fetchEntry[s])
        );

        assign buildHit[s]   = tagRd[s][TAG_RD_BUILD] == bTag;
        assign vldUseful[s]  = valid[s][bIdx] & useful[s];
        assign fetchExist[s] = valid[s][fIdx] & (tagRd[s][TAG_RD_FETCH] == fTag);
    end

    //////////////////////////////////////////////////
    // build status
    //////////////////////////////////////////////////
    logic isPair;

    // both halves live and tagged alike
    assign isPair = valid[SLOT_LOWER][bIdx] & valid[SLOT_UPPER][bIdx]
                  & (tagRd[SLOT_LOWER][TAG_RD_BUILD] == tagRd[SLOT_UPPER][TAG_RD_BUILD]);

    assign buildStatus.exist  = |(vldUseful & buildHit);
    assign buildStatus.insert = ~|vldUseful;                // nothing to evict
    assign buildStatus.isPair = isPair;

    // valid bits, a pair gets replaced, otherwise merged
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
        end else if (build.en) begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                if (isPair) begin
                    valid[s][bIdx] <= useful[s];            // new pair owns the set
                end else begin
                    valid[s][bIdx] <= valid[s][bIdx] | useful[s];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // execute-stage check
    //////////////////////////////////////////////////
    logic exSlot;

    assign exSlot  = exPc[2];                               // 0 lower, 1 upper
    assign exExist = valid[exSlot][eIdx] & (tagRd[exSlot][TAG_RD_CHECK] == eTag);

    // a useful lower build must leave its slot valid
    lowerBuildValid: assert property (
        @(posedge clk) disable iff (!rstn)
        (build.en && isUseful(build.lower.brType)) |=> valid[SLOT_LOWER][$past(bIdx)]
    ) else $error("lower valid bit not set after build");

endmodule

// File: hdl/patternHistoryTable.sv
`timescale 1ns/1ps

module patternHistoryTable (
    input  logic                                    clk,
    input  logic                                    rstn,
    input  bpPkg::resolveT                          resolve,
    input  bpPkg::pcT                               fetchPc,
    output bpPkg::histEntryT [bpPkg::NUM_SLOTS-1:0] fetchHist   // [0] even, [1] odd
);

    import bpPkg::*;

    histIdxT                  rIdx;                         // resolved instruction
    histIdxT [HIST_READS-1:0] histRdAddr;
    histEntryT [HIST_READS-1:0] histRd;
    histEntryT                initEntry;
    histEntryT                updatedEntry;
    histEntryT                wrEntry;
    logic [HIST_SETS-1:0]     valid;                        // entry seen at least once
    logic                     back;

    assign rIdx = histIdx(resolve.pc);

    assign histRdAddr[HIST_RD_RESOLVE] = rIdx;
    assign histRdAddr[HIST_RD_EVEN]    = {pairIdx(fetchPc), 1'b0};
    assign histRdAddr[HIST_RD_ODD]     = {pairIdx(fetchPc), 1'b1};

    //////////////////////////////////////////////////
    // first-time entry
    //////////////////////////////////////////////////
    assign back = resolve.target[ADDR_WIDTH-1:2] < resolve.pc[ADDR_WIDTH-1:2];

    always_comb begin
        initEntry = '0;
        case (resolve.brType)
            COND: begin
                initEntry.lastOutcomes = {back, resolve.taken};
                initEntry.ctr          = back ? CTR_INIT_BACK : CTR_INIT_FWD;  // loops lean taken
            end
            JUMP, OTHER: begin
                initEntry = '1;                             // always taken
            end
            NONE: begin
                initEntry = '0;
            end
        endcase
    end

    historyUpdate uHistoryUpdate (
        .old     (histRd[HIST_RD_RESOLVE]),
        .taken   (resolve.taken),
        .updated (updatedEntry)
    );

    assign wrEntry = valid[rIdx] ? updatedEntry : initEntry;

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////
    regFile #(
        .payloadT  (histEntryT),
        .NUM_READS (HIST_READS),
        .IDX_WIDTH (HIST_IDX_WIDTH)
    ) uHistFile (
        .clk    (clk),
        .wrEn   (resolve.en),
        .wrAddr (rIdx),
        .wrData (wrEntry),
        .rdAddr (histRdAddr),
        .rdData (histRd)
    );

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
        end else if (resolve.en) begin
            valid[rIdx] <= 1'b1;                            // set on first resolve
        end
    end

    assign fetchHist[SLOT_LOWER] = histRd[HIST_RD_EVEN];
    assign fetchHist[SLOT_UPPER] = histRd[HIST_RD_ODD];

    // first resolve of OTHER stores saturated counters, seen on a revisit
    otherInitSaturated: assert property (
        @(posedge clk) disable iff (!rstn)
        (resolve.en && resolve.brType == OTHER && !valid[rIdx])
            |=> (rIdx != $past(rIdx)) || (&histRd[HIST_RD_RESOLVE].ctr)
    ) else $error("OTHER init left a counter below 11");

endmodule

// File: hdl/branchPredictor.sv
`timescale 1ns/1ps

module branchPredictor (
    input  logic               clk,
    input  logic               rstn,
    input  bpPkg::buildReqT    build,                       // decode stage pair
    input  bpPkg::pcT          exPc,                        // execute stage check
    input  bpPkg::pcT          fetchPc,                     // fetch stage predict
    input  bpPkg::resolveT     resolve,                     // branch outcome
    output bpPkg::buildStatusT buildStatus,
    output logic               exExist,
    output bpPkg::fetchPredT   fetchPred
);

    import bpPkg::*;

    logic      [NUM_SLOTS-1:0] fetchExist;
    slotEntryT [NUM_SLOTS-1:0] fetchEntry;
    histEntryT [NUM_SLOTS-1:0] fetchHist;

    //////////////////////////////////////////////////
    // target buffer
    //////////////////////////////////////////////////
    pairTargetBuffer uPairTargetBuffer (
        .clk         (clk),
        .rstn        (rstn),
        .build       (build),
        .exPc        (exPc),
        .fetchPc     (fetchPc),
        .buildStatus (buildStatus),
        .exExist     (exExist),
        .fetchExist  (fetchExist),
        .fetchEntry  (fetchEntry)
    );

    //////////////////////////////////////////////////
    // direction history
    //////////////////////////////////////////////////
    patternHistoryTable uPatternHistoryTable (
        .clk       (clk),
        .rstn      (rstn),
        .resolve   (resolve),
        .fetchPc   (fetchPc),
        .fetchHist (fetchHist)
    );

    // fetch bundle, lower is the even instruction
    assign fetchPred.lower.exist = fetchExist[SLOT_LOWER];
    assign fetchPred.lower.entry = fetchEntry[SLOT_LOWER];
    assign fetchPred.lower.hist  = fetchHist[SLOT_LOWER];
    assign fetchPred.upper.exist = fetchExist[SLOT_UPPER];
    assign fetchPred.upper.entry = fetchEntry[SLOT_UPPER];
    assign fetchPred.upper.hist  = fetchHist[SLOT_UPPER];

endmodule

// File: sim/predictorModel.sv
`timescale 1ns/1ps

module predictorModel (
    input  logic               clk,
    input  logic               rstn,
    input  bpPkg::buildReqT    build,
    input  bpPkg::pcT          exPc,
    input  bpPkg::pcT          fetchPc,
    input  bpPkg::resolveT     resolve,
    input  bpPkg::buildStatusT buildStatus,                 // DUT outputs under check
    input  logic               exExist,
    input  bpPkg::fetchPredT   fetchPred,
    output int                 errors
);

    import bpPkg::*;

    logic        tValid [2][32];                            // shadow target buffer
    logic [23:0] tTag   [2][32];
    slotEntryT   tEntry [2][32];
    logic        hValid [64];                               // shadow history table
    histEntryT   hEntry [64];

    slotReqT     req [2];
    slotPredT    dutSlot [2];
    logic [1:0]  reqUseful;
    logic [4:0]  bIdx;
    logic [4:0]  eIdx;
    logic [4:0]  fIdx;
    logic [5:0]  rIdx;
    logic [5:0]  fhIdx [2];
    buildStatusT expStatus;
    logic        expEx;
    logic [1:0]  expFetch;

    initial errors = 0;

    // first resolve of an entry
    function automatic histEntryT initHist(branchTypeT t, logic taken, pcT pc, pcT target);
        histEntryT h;
        logic      back;
        back = target[31:2] < pc[31:2];                     // backward branch
        h = '0;
        if (t == JUMP || t == OTHER) begin
            h = 10'h3ff;
        end else if (t == COND) begin
            h.lastOutcomes = {back, taken};
            h.ctr[3] = 2'b10;
            h.ctr[2] = back ? 2'b10 : 2'b01;
            h.ctr[1] = back ? 2'b10 : 2'b01;
            h.ctr[0] = 2'b01;
        end
        return h;
    endfunction

    // later resolves, clamp to 0..3
    function automatic histEntryT stepHist(histEntryT h, logic taken);
        histEntryT n;
        int        k;
        int        c;
        n = h;
        k = int'(h.lastOutcomes);
        c = int'(h.ctr[k]) + (taken ? 1 : -1);
        if (c > 3) c = 3;
        if (c < 0) c = 0;
        n.ctr[k] = c[1:0];
        n.lastOutcomes = {h.lastOutcomes[0], taken};
        return n;
    endfunction

    //////////////////////////////////////////////////
    // expected outputs
    //////////////////////////////////////////////////
    always_comb begin
        req[0] = build.lower;
        req[1] = build.upper;
        bIdx = build.pc[7:3];
        eIdx = exPc[7:3];
        fIdx = fetchPc[7:3];
        rIdx = resolve.pc[7:2];
        expStatus.isPair = tValid[0][bIdx] && tValid[1][bIdx]
                         && (tTag[0][bIdx] == tTag[1][bIdx]);
        expStatus.exist  = 1'b0;
        expStatus.insert = 1'b1;
        for (int s = 0; s < 2; s++) begin
            reqUseful[s] = (req[s].brType == COND) || (req[s].brType == JUMP);
            if (tValid[s][bIdx] && reqUseful[s]) begin
                expStatus.insert = 1'b0;                    // something live to hit
                if (tTag[s][bIdx] == build.pc[31:8]) expStatus.exist = 1'b1;
            end
            expFetch[s] = tValid[s][fIdx] && (tTag[s][fIdx] == fetchPc[31:8]);
            fhIdx[s] = {fIdx, (s == 1)};                    // odd is upper
        end
        expEx = tValid[exPc[2]][eIdx] && (tTag[exPc[2]][eIdx] == exPc[31:8]);
    end

    assign dutSlot[0] = fetchPred.lower;
    assign dutSlot[1] = fetchPred.upper;

    //////////////////////////////////////////////////
    // shadow state
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int s = 0; s < 2; s++) begin
                for (int i = 0; i < 32; i++) tValid[s][i] <= 1'b0;
            end
            for (int i = 0; i < 64; i++) hValid[i] <= 1'b0;
        end else begin
            if (build.en) begin
                for (int s = 0; s < 2; s++) begin
                    if (reqUseful[s]) begin
                        tTag[s][bIdx]   <= build.pc[31:8];
                        tEntry[s][bIdx] <= {req[s].target[31:2], req[s].brType};
                    end
                    tValid[s][bIdx] <= expStatus.isPair ? reqUseful[s]
                                                        : (tValid[s][bIdx] | reqUseful[s]);
                end
            end
            if (resolve.en) begin
                hEntry[rIdx] <= hValid[rIdx] ? stepHist(hEntry[rIdx], resolve.taken)
                    : initHist(resolve.brType, resolve.taken, resolve.pc, resolve.target);
                hValid[rIdx] <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // checks on the DUT ports
    //////////////////////////////////////////////////
    statusMatch: assert property (@(posedge clk) disable iff (!rstn) buildStatus == expStatus)
        else begin
            errors++;
            $display("[ERROR] %0t buildStatus %b, expected %b", $time, buildStatus, expStatus);
        end

    exMatch: assert property (@(posedge clk) disable iff (!rstn) exExist == expEx)
        else begin
            errors++;
            $display("[ERROR] %0t exExist %b, expected %b", $time, exExist, expEx);
        end

    for (genvar s = 0; s < 2; s++) begin : gSlot
        existMatch: assert property (@(posedge clk) disable iff (!rstn)
            dutSlot[s].exist == expFetch[s])
            else begin
                errors++;
                $display("[ERROR] %0t slot %0d fetch exist %b, expected %b",
                         $time, s, dutSlot[s].exist, expFetch[s]);
            end

        entryMatch: assert property (@(posedge clk) disable iff (!rstn)
            !expFetch[s] || (dutSlot[s].entry == tEntry[s][fIdx]))
            else begin
                errors++;
                $display("[ERROR] %0t slot %0d entry %h, expected %h",
                         $time, s, dutSlot[s].entry, tEntry[s][fIdx]);
            end

        histMatch: assert property (@(posedge clk) disable iff (!rstn)
            !hValid[fhIdx[s]] || (dutSlot[s].hist == hEntry[fhIdx[s]]))
            else begin
                errors++;
                $display("[ERROR] %0t slot %0d history %b, expected %b",
                         $time, s, dutSlot[s].hist, hEntry[fhIdx[s]]);
            end
    end

endmodule

// File: sim/branchPredictorTb.sv
`timescale 1ns/1ps

module branchPredictorTb;

    import bpPkg::*;

    localparam int          CLK_PERIOD      = 10;
    localparam int          RESET_CYCLES    = 4;
    localparam int          DIRECTED_CYCLES = 80;           // upper bound of directed part
    localparam int          RANDOM_CYCLES   = 2000;
    localparam int          TOTAL_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;
    localparam int          TIMEOUT_NS      = TOTAL_CYCLES * CLK_PERIOD + 500;
    localparam logic [31:0] SEED            = 32'h22ff2ad3;

    logic        clk;
    logic        rstn;
    buildReqT    build;
    pcT          exPc;
    pcT          fetchPc;
    resolveT     resolve;
    buildStatusT buildStatus;
    logic        exExist;
    fetchPredT   fetchPred;
    int          errors;
    int          cycles;

    branchPredictor u_branchPredictor (
        .clk(clk), .rstn(rstn), .build(build), .exPc(exPc), .fetchPc(fetchPc),
        .resolve(resolve), .buildStatus(buildStatus), .exExist(exExist), .fetchPred(fetchPred)
    );

    predictorModel uModel (
        .clk(clk), .rstn(rstn), .build(build), .exPc(exPc), .fetchPc(fetchPc),
        .resolve(resolve), .buildStatus(buildStatus), .exExist(exExist),
        .fetchPred(fetchPred), .errors(errors)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // strobes drop on the falling edge unless re-driven
    task automatic nextCycle();
        @(negedge clk);
        build.en   = 1'b0;
        resolve.en = 1'b0;
        cycles++;
    endtask

    // few tags and few indices so sets collide
    function automatic pcT randomPc();
        logic [23:0] tag;
        logic [4:0]  idx;
        tag = 24'h00a000 + 24'($urandom_range(0, 2));
        idx = 5'($urandom_range(0, 3));
        return {tag, idx, 1'($urandom_range(0, 1)), 2'b00};
    endfunction

    function automatic branchTypeT randomType();
        return branchTypeT'(2'($urandom_range(0, 3)));
    endfunction

    task automatic driveBuild(pcT pc, branchTypeT lt, pcT ltgt, branchTypeT ut, pcT utgt);
        build.en           = 1'b1;
        build.pc           = pc & ~32'h7;                   // pair aligned
        build.lower.brType = lt;
        build.lower.target = ltgt;
        build.upper.brType = ut;
        build.upper.target = utgt;
    endtask

    task automatic driveResolve(pcT pc, branchTypeT t, logic taken, pcT target);
        resolve.en     = 1'b1;
        resolve.pc     = pc;
        resolve.brType = t;
        resolve.taken  = taken;
        resolve.target = target;
    endtask

    initial begin
        pcT pc;
        void'($urandom(SEED));
        cycles = 0;
        rstn = 1'b0;
        build = '0;
        resolve = '0;
        exPc = '0;
        fetchPc = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        // empty buffer after reset
        nextCycle();
        fetchPc = 32'h0001_2340;
        exPc = 32'h0001_2344;
        driveBuild(32'h0001_2340, COND, 32'h0001_2000, JUMP, 32'h0001_3000);
        nextCycle();
        nextCycle();
        exPc = 32'h0001_2340;                               // lower slot check
        // rebuild over the pair with a new tag
        nextCycle();
        driveBuild(32'h0005_6740, NONE, 32'h0, COND, 32'h0005_6800);
        nextCycle();
        nextCycle();
        fetchPc = 32'h0005_6740;
        exPc = 32'h0005_6744;

        ////////////////////////////////////////////////
        // first resolves of every type and direction
        ////////////////////////////////////////////////
        for (int c = 0; c < 16; c++) begin
            nextCycle();
            pc = 32'h0000_1000 + 32'(c * 4);
            driveResolve(pc, branchTypeT'(2'(c >> 2)), c[1], c[0] ? pc - 32'h40 : pc + 32'h40);
            fetchPc = pc;
        end
        for (int p = 0; p < 8; p++) begin
            nextCycle();
            fetchPc = 32'h0000_1000 + 32'(p * 8);
        end

        // same branch again and again so counters pin at both ends
        for (int r = 0; r < 30; r++) begin
            nextCycle();
            driveResolve(32'h0000_2040, COND, (r < 10) || (r >= 20 && $urandom_range(0, 1) == 1),
                         32'h0000_2000);
            fetchPc = 32'h0000_2040;
        end

        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            nextCycle();
            if ($urandom_range(0, 1) == 1) begin
                driveBuild(randomPc(), randomType(), $urandom(), randomType(), $urandom());
            end
            if ($urandom_range(0, 1) == 1) begin
                driveResolve(randomPc(), randomType(), 1'($urandom_range(0, 1)), $urandom());
            end
            exPc = randomPc();
            fetchPc = randomPc();
        end
        nextCycle();
        nextCycle();                                        // last writes get looked at

        $display("run done: %0d cycles, %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: stimulus did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: sources.f
hdl/bpPkg.sv
hdl/regFile.sv
hdl/historyUpdate.sv
hdl/pairTargetBuffer.sv
hdl/patternHistoryTable.sv
hdl/branchPredictor.sv
sim/predictorModel.sv
sim/branchPredictorTb.sv

// File: run.sh
#!/bin/sh
# compile and run with Verilator, then scan the log for the verdict
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module branchPredictorTb -o simv \
    && ./obj_dir/simv; } > sim.log 2>&1 \
    || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
